//--- src.f
hdl/pulse_tx_pkg.sv
hdl/pulse_tx_regs.sv
hdl/pulse_sequencer.sv
hdl/symbol_timer.sv
hdl/pulse_output_stage.sv
hdl/pulse_transmitter.sv
bench/pulse_transmitter_chk.sv
bench/tb_pulse_transmitter.sv

//--- Bender.yml
package:
  name: pulse_transmitter

sources:
  - hdl/pulse_tx_pkg.sv
  - hdl/pulse_tx_regs.sv
  - hdl/pulse_sequencer.sv
  - hdl/symbol_timer.sv
  - hdl/pulse_output_stage.sv
  - hdl/pulse_transmitter.sv
  - target: test
    files:
      - bench/pulse_transmitter_chk.sv
      - bench/tb_pulse_transmitter.sv

//--- bench/tb_pulse_transmitter.sv
// Testbench with clock, reset, bus writes, program scenarios and the closing result line
`timescale 1ns/1ps

module tb_pulse_transmitter;
    import pulse_tx_pkg::*;

    logic        clk;
    logic        rst_n;
    bus_req_t    bus;
    logic [31:0] read_data;
    logic        irq;
    logic        tx_out;
    logic        carrier_out;
    logic        active;

    logic [31:0] prog_words [PROG_WORDS];
    int          durations [4];
    int          check_errors = 0;
    int          high_cycles = 0;
    logic        line_invert = 1'b0;
    logic [31:0] ctrl_cfg;

    pulse_transmitter DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus),
        .read_data   (read_data),
        .irq         (irq),
        .tx_out      (tx_out),
        .carrier_out (carrier_out),
        .active      (active)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Line high time while active, sampled mid-cycle
    always @(negedge clk) begin
        if (active && (tx_out ^ line_invert)) begin
            high_cycles++;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [5:0] reg_addr(input logic [2:0] idx);
        return {1'b0, idx, 2'b00};
    endfunction

    function automatic logic [5:0] prog_addr(input int idx);
        return {1'b1, 3'(idx), 2'b00};
    endfunction

    // Control word without command or clear bits
    function automatic logic [31:0] ctrl_bits(input irq_t mask, input logic loop_all,
                                              input logic idle, input logic inv,
                                              input logic car_en, input logic two_bit,
                                              input logic [7:0] sym_codes);
        logic [31:0] w;
        w        = '0;
        w[10:8]  = mask;
        w[12]    = loop_all;
        w[13]    = idle;
        w[14]    = inv;
        w[15]    = car_en;
        w[17]    = two_bit;
        w[25:18] = sym_codes;
        return w;
    endfunction

    // High-level cycles of a two-bit program walked by the PC and loop rules
    function automatic int expected_high_cycles(input logic [7:0] first,
                                                input logic [7:0] last,
                                                input logic [7:0] back,
                                                input int loops, input int pre_exp);
        logic [7:0]  pc;
        logic [31:0] word;
        logic [1:0]  code;
        int          left;
        int          total;
        int          guard;
        logic        done;
        pc    = first;
        left  = loops;
        total = 0;
        guard = 0;
        done  = 1'b0;
        while (!done && guard < 1024) begin
            word = prog_words[pc[7:5]];
            code = 2'(word >> (2 * pc[4:1]));
            if (code[1]) begin
                total += (durations[code] + 1) << pre_exp;
            end
            if (pc == last) begin
                if (left == 0) begin
                    done = 1'b1;
                end else begin
                    pc = back;
                    left--;
                end
            end else begin
                pc = pc + 8'd2;
            end
            guard++;
        end
        return total;
    endfunction

    task automatic expect_equal(input string what, input int got, input int want);
        assert (got == want) else begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            check_errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out waiting for %s at %0t ns", what, $time);
        $display("Checks failed: %0d, assertions failed: %0d",
                 check_errors, DUT.u_chk.fail_count);
        $display("TEST FAIL");
        $finish;
    endtask

    // One-cycle write strobe, then the bus goes idle
    task automatic bus_write(input logic [5:0] addr, input logic [31:0] data);
        @(posedge clk);
        bus <= '{addr: addr, wdata: data, write: 1'b1};
        @(posedge clk);
        bus <= '{addr: 6'd0, wdata: 32'd0, write: 1'b0};
    endtask

    // Running bit sits at the start bit position of the read word
    task automatic wait_running(input logic want, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while ((read_data[STATUS_START_BIT] !== want) && (n < limit)) begin
            n++;
            @(negedge clk);
        end
        if (read_data[STATUS_START_BIT] !== want) begin
            abort_on_timeout(want ? "running to rise" : "running to fall");
        end
    endtask

    task automatic run_program(input int limit);
        bus_write(reg_addr(REG_CTRL), ctrl_cfg | (32'd1 << STATUS_START_BIT));
        wait_running(1'b1, 4);
        wait_running(1'b0, limit);
    endtask

    task automatic clear_flags();
        bus_write(reg_addr(REG_CTRL), ctrl_cfg | 32'h7);
        @(negedge clk);
        expect_equal("flags after clear", read_data[2:0], 0);
        expect_equal("irq after clear", irq, 0);
    endtask

    // ----------------------------------------
    // Scenarios
    // ----------------------------------------
    initial begin
        int base;
        int seed_val;
        rst_n    = 1'b0;
        bus      = '0;
        ctrl_cfg = '0;
        seed_val = $urandom(4);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_equal("read data after reset", read_data, 0);
        expect_equal("irq after reset", irq, 0);

        // Random program words, fixed duration set, prescaler 2^1
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_words[i] = $urandom;
            bus_write(prog_addr(i), prog_words[i]);
        end
        durations = '{2, 5, 3, 7};
        bus_write(reg_addr(REG_DUR), {8'(durations[3]), 8'(durations[2]),
                                      8'(durations[1]), 8'(durations[0])});
        bus_write(reg_addr(REG_PRESCALE), 32'h1000_0000);

        // Two-bit program, start 0, end 10, loop back to 4 twice
        bus_write(reg_addr(REG_PROG), {8'd2, 8'd4, 8'd10, 8'd0});
        ctrl_cfg = ctrl_bits(3'b111, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'h00);
        bus_write(reg_addr(REG_CTRL), ctrl_cfg);
        line_invert = 1'b0;
        base = high_cycles;
        run_program(5000);
        expect_equal("high cycles", high_cycles - base,
                     expected_high_cycles(8'd0, 8'd10, 8'd4, 2, 1));
        expect_equal("end flag", read_data[IRQ_END], 1);
        expect_equal("irq at end", irq, 1);
        clear_flags();

        // One-bit program with carrier and inverted line
        bus_write(reg_addr(REG_PROG), {8'd0, 8'd0, 8'd5, 8'd0});
        bus_write(reg_addr(REG_CARRIER), 32'd3);
        ctrl_cfg = ctrl_bits(3'b111, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 8'h72);
        bus_write(reg_addr(REG_CTRL), ctrl_cfg);
        line_invert = 1'b1;
        run_program(5000);
        expect_equal("end flag", read_data[IRQ_END], 1);
        clear_flags();

        // Endless loop cut short by a stop write
        bus_write(reg_addr(REG_PROG), {8'd0, 8'd4, 8'd10, 8'd0});
        ctrl_cfg = ctrl_bits(3'b111, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 8'h00);
        line_invert = 1'b0;
        bus_write(reg_addr(REG_CTRL), ctrl_cfg | (32'd1 << STATUS_START_BIT));
        wait_running(1'b1, 4);
        repeat (200) @(posedge clk);
        bus_write(reg_addr(REG_CTRL), ctrl_cfg | (32'd1 << STATUS_STOP_BIT));
        wait_running(1'b0, 4);
        expect_equal("loop flag after stop", read_data[IRQ_LOOP], 1);
        expect_equal("end flag after stop", read_data[IRQ_END], 0);
        clear_flags();

        repeat (5) @(posedge clk);
        $display("Checks failed: %0d, assertions failed: %0d",
                 check_errors, DUT.u_chk.fail_count);
        if ((check_errors == 0) && (DUT.u_chk.fail_count == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- bench/pulse_transmitter_chk.sv
// Checker module with concurrent assertions on the line, carrier, run control and flags
`timescale 1ns/1ps

module pulse_transmitter_chk (
    input logic                     clk,
    input logic                     rst_n,
    input pulse_tx_pkg::bus_req_t   bus,
    input logic [31:0]              read_data,
    input logic                     irq,
    input logic                     tx_out,
    input logic                     carrier_out,
    input logic                     active,
    input pulse_tx_pkg::pulse_cfg_t cfg,
    input logic                     running,
    input logic                     finished,
    input pulse_tx_pkg::irq_t       irq_events
);
    import pulse_tx_pkg::*;

    int unsigned fail_count = 0;
    logic        ctrl_write;
    logic        active_q;
    logic        carrier_q;
    // Cycles the carrier has held its level so far
    logic [11:0] hold_len;

    assign ctrl_write = bus.write && !bus.addr[5] && (bus.addr[4:2] == REG_CTRL);

    // ----------------------------------------
    // Carrier level tracking
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q  <= 1'b0;
            carrier_q <= 1'b0;
            hold_len  <= '0;
        end else begin
            active_q  <= active;
            carrier_q <= carrier_out;
            if (!active) begin
                hold_len <= '0;
            end else if (!active_q || (carrier_out != carrier_q)) begin
                hold_len <= 12'd1;
            end else begin
                hold_len <= hold_len + 12'd1;
            end
        end
    end

    // ----------------------------------------
    // Assertions
    // ----------------------------------------
    // Outputs and read data come out of reset quiet
    a_reset_state: assert property (@(posedge clk)
        !rst_n |=> (!irq && !active && !carrier_out && !tx_out && (read_data == '0)))
        else begin $error("outputs not quiet after reset"); fail_count++; end

    a_idle_level: assert property (@(posedge clk) disable iff (!rst_n)
        !active |-> (tx_out == (cfg.idle_level ^ cfg.invert)))
        else begin $error("line not at idle level while inactive"); fail_count++; end

    // Carrier low must keep the line at its off level
    a_carrier_gate: assert property (@(posedge clk) disable iff (!rst_n)
        (active && cfg.carrier_en && !carrier_out) |-> !(tx_out ^ cfg.invert))
        else begin $error("line high while carrier low"); fail_count++; end

    a_carrier_period: assert property (@(posedge clk) disable iff (!rst_n)
        (active && active_q && (carrier_out != carrier_q))
        |-> (hold_len == (12'(cfg.carrier_half) + 12'd1)))
        else begin $error("carrier half period wrong"); fail_count++; end

    a_end_flag: assert property (@(posedge clk) disable iff (!rst_n)
        (finished && cfg.irq_mask[IRQ_END]) |=> (read_data[IRQ_END] && irq))
        else begin $error("end flag or irq missing at end of program"); fail_count++; end

    a_finish_stops: assert property (@(posedge clk) disable iff (!rst_n)
        finished |=> (!running && !read_data[STATUS_START_BIT]))
        else begin $error("running still set after end of program"); fail_count++; end

    a_stop_write: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl_write && bus.wdata[STATUS_STOP_BIT]) |-> ##[1:2] !running)
        else begin $error("stop write did not clear running"); fail_count++; end

    // Clearing all flags with no event pending drops irq
    a_flag_clear: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl_write && (bus.wdata[2:0] == 3'b111) && ((irq_events & cfg.irq_mask) == '0))
        |=> ((read_data[2:0] == '0) && !irq))
        else begin $error("flags or irq not cleared by write"); fail_count++; end

endmodule

bind pulse_transmitter pulse_transmitter_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (bus),
    .read_data   (read_data),
    .irq         (irq),
    .tx_out      (tx_out),
    .carrier_out (carrier_out),
    .active      (active),
    .cfg         (cfg),
    .running     (running),
    .finished    (finished),
    .irq_events  (irq_events)
);

//--- hdl/pulse_transmitter.sv
// Pulse transmitter top level joining registers, sequencer, timer and output stage
`timescale 1ns/1ps

module pulse_transmitter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pulse_tx_pkg::bus_req_t bus,
    output logic [31:0]            read_data,
    output logic                   irq,
    output logic                   tx_out,
    output logic                   carrier_out,
    output logic                   active
);
    import pulse_tx_pkg::*;

    pulse_cfg_t  cfg;
    seq_status_t status;
    logic        running;
    logic [31:0] prog_word;
    logic [2:0]  word_index;
    irq_t        seq_events;
    irq_t        irq_events;
    duration_t   duration;
    prescale_t   prescale;
    logic        level;
    logic        end_of_program;
    logic        request;
    logic        symbol_done;
    logic        timer_enable;
    logic        boundary;
    logic        finished;

    // Loop and end events from the sequencer, symbol event per boundary
    assign irq_events = {seq_events[IRQ_END], seq_events[IRQ_LOOP], boundary};

    pulse_tx_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus),
        .word_index (word_index),
        .events     (irq_events),
        .finished   (finished),
        .status     (status),
        .cfg        (cfg),
        .running    (running),
        .prog_word  (prog_word),
        .read_data  (read_data),
        .irq        (irq)
    );

    pulse_sequencer u_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .running        (running),
        .prog_word      (prog_word),
        .request        (request),
        .word_index     (word_index),
        .duration       (duration),
        .prescale       (prescale),
        .level          (level),
        .events         (seq_events),
        .end_of_program (end_of_program),
        .status         (status)
    );

    symbol_timer u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (timer_enable),
        .duration    (duration),
        .prescale    (prescale),
        .request     (request),
        .symbol_done (symbol_done)
    );

    pulse_output_stage u_output (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .running        (running),
        .level          (level),
        .symbol_done    (symbol_done),
        .end_of_program (end_of_program),
        .timer_enable   (timer_enable),
        .boundary       (boundary),
        .finished       (finished),
        .tx_out         (tx_out),
        .carrier_out    (carrier_out),
        .active         (active)
    );

endmodule

//--- hdl/pulse_output_stage.sv
// Start window, saved line level, carrier generator, idle level and inversion
`timescale 1ns/1ps

module pulse_output_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pulse_tx_pkg::pulse_cfg_t cfg,
    input  logic                     running,
    input  logic                     level,
    input  logic                     symbol_done,
    input  logic                     end_of_program,
    output logic                     timer_enable,
    output logic                     boundary,
    output logic                     finished,
    output logic                     tx_out,
    output logic                     carrier_out,
    output logic                     active
);
    import pulse_tx_pkg::*;

    logic     running_q;
    logic     start_pulse;
    logic     start_d1;
    logic     start_d2;
    logic     saved_level;
    carrier_t car_cnt;
    logic     car_q;
    logic     modulated;

    // ----------------------------------------
    // Start window
    // ----------------------------------------
    assign start_pulse = running && !running_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running_q <= 1'b0;
            start_d1  <= 1'b0;
            start_d2  <= 1'b0;
        end else begin
            running_q <= running;
            start_d1  <= start_pulse;
            start_d2  <= start_d1;
        end
    end

    // Line is live once the first code has been fetched and saved
    assign active       = running && !start_pulse && !start_d1 && !start_d2;
    assign timer_enable = active;

    // First level loads on start_d1, the rest on each symbol end
    assign boundary = start_d1 || symbol_done;
    assign finished = boundary && end_of_program;

    always_ff @(posedge clk) begin
        if (!rst_n || !running) begin
            saved_level <= 1'b0;
        end else if (boundary) begin
            saved_level <= level;
        end
    end

    // ----------------------------------------
    // Carrier
    // ----------------------------------------
    // Toggles every carrier_half + 1 cycles, starting low
    always_ff @(posedge clk) begin
        if (!rst_n || !active) begin
            car_cnt <= '0;
            car_q   <= 1'b0;
        end else if (car_cnt == cfg.carrier_half) begin
            car_cnt <= '0;
            car_q   <= !car_q;
        end else begin
            car_cnt <= car_cnt + 1'b1;
        end
    end

    assign carrier_out = car_q && active;

    // Gate with carrier, idle when inactive, then optional inversion
    assign modulated = cfg.carrier_en ? (saved_level && car_q) : saved_level;
    assign tx_out    = (active ? modulated : cfg.idle_level) ^ cfg.invert;

endmodule

//--- hdl/symbol_timer.sv
// Prescaled countdown timer for symbol lengths, with early request
`timescale 1ns/1ps

module symbol_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable,
    input  pulse_tx_pkg::duration_t duration,
    input  pulse_tx_pkg::prescale_t prescale,
    output logic                    request,
    output logic                    symbol_done
);
    import pulse_tx_pkg::*;

    logic [PRESCALE_CNT_BITS-1:0] pre_cnt;
    logic [PRESCALE_CNT_BITS-1:0] pre_max;
    duration_t                    dur_cnt;
    // Loaded symbol has zero duration
    logic                         single;
    logic                         pre_last;

    // 2^prescale cycles per duration tick
    assign pre_max  = (PRESCALE_CNT_BITS'(1) << prescale) - PRESCALE_CNT_BITS'(1);
    assign pre_last = (pre_cnt == pre_max);

    assign symbol_done = enable && pre_last && (dur_cnt == '0);

    // Request one cycle ahead so the next code is decoded at symbol_done
    always_comb begin
        if (pre_max == '0) begin
            request = enable && ((dur_cnt == 8'd1) || single);
        end else begin
            request = enable && (dur_cnt == '0) && (pre_cnt == pre_max - 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            dur_cnt <= '0;
            single  <= 1'b0;
        end else if (!enable || symbol_done) begin
            // Reload from the code now on the sequencer output
            pre_cnt <= '0;
            dur_cnt <= duration;
            single  <= (duration == '0);
        end else if (pre_last) begin
            pre_cnt <= '0;
            dur_cnt <= dur_cnt - 8'd1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

endmodule

//--- hdl/pulse_sequencer.sv
// Program counter, loop counter, end-of-program tracking and symbol decode
`timescale 1ns/1ps

module pulse_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pulse_tx_pkg::pulse_cfg_t  cfg,
    input  logic                      running,
    input  logic [31:0]               prog_word,
    input  logic                      request,
    output logic [2:0]                word_index,
    output pulse_tx_pkg::duration_t   duration,
    output pulse_tx_pkg::prescale_t   prescale,
    output logic                      level,
    output pulse_tx_pkg::irq_t        events,
    output logic                      end_of_program,
    output pulse_tx_pkg::seq_status_t status
);
    import pulse_tx_pkg::*;

    pc_t       pc;
    loop_cnt_t loop_cnt;
    // Second code of an element in one-bit mode
    logic      half;
    logic      advance;
    logic      at_end;
    logic      do_step;
    logic      do_loop;
    logic      do_end;
    symbol_t   raw_code;
    symbol_t   code;

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    // One-bit mode moves on only after both codes of an element
    assign advance = request && (cfg.two_bit_mode || half);
    assign at_end  = (pc == cfg.end_idx);
    assign do_step = advance && !at_end;
    assign do_loop = advance && at_end && (cfg.loop_forever || loop_cnt != '0);
    assign do_end  = advance && at_end && !(cfg.loop_forever || loop_cnt != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc             <= '0;
            loop_cnt       <= '0;
            half           <= 1'b0;
            end_of_program <= 1'b0;
        end else if (!running) begin
            // Parked at the start of the program
            pc             <= cfg.start_idx;
            loop_cnt       <= cfg.loop_count;
            half           <= 1'b0;
            end_of_program <= 1'b0;
        end else begin
            if (request) begin
                half <= !half;
            end
            if (do_step) begin
                pc <= cfg.two_bit_mode ? pc + 8'd2 : pc + 8'd1;
            end
            if (do_loop) begin
                pc       <= cfg.loopback_idx;
                loop_cnt <= loop_cnt - 8'd1;
            end
            // Last code is already decoded, flush it before stopping
            if (do_end) begin
                end_of_program <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Symbol decode
    // ----------------------------------------
    // PC is a bit index into 32-bit words, so pc[7:5] picks the word
    assign word_index = pc[7 -: PROG_ADDR_BITS];
    assign raw_code   = prog_word[{pc[4:1], 1'b0} +: 2];

    always_comb begin
        if (cfg.two_bit_mode) begin
            code = raw_code;
        end else if (prog_word[pc[4:0]]) begin
            code = half ? cfg.high_sym1 : cfg.high_sym0;
        end else begin
            code = half ? cfg.low_sym1 : cfg.low_sym0;
        end

        case (code)
            2'd0:    duration = cfg.dur_low_a;
            2'd1:    duration = cfg.dur_low_b;
            2'd2:    duration = cfg.dur_high_a;
            default: duration = cfg.dur_high_b;
        endcase
    end

    assign level    = code[1];
    assign prescale = cfg.prescale;

    // Symbol event comes from the output stage boundary
    always_comb begin
        events             = '0;
        events[IRQ_SYMBOL] = 1'b0;
        events[IRQ_LOOP]   = do_loop;
        events[IRQ_END]    = do_end;
    end

    assign status = '{pc: pc, loop_cnt: loop_cnt};

endmodule

//--- hdl/pulse_tx_regs.sv
// Register file, program memory, run control and sticky interrupt flags
`timescale 1ns/1ps

module pulse_tx_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pulse_tx_pkg::bus_req_t    bus,
    input  logic [2:0]                word_index,
    input  pulse_tx_pkg::irq_t        events,
    input  logic                      finished,
    input  pulse_tx_pkg::seq_status_t status,
    output pulse_tx_pkg::pulse_cfg_t  cfg,
    output logic                      running,
    output logic [31:0]               prog_word,
    output logic [31:0]               read_data,
    output logic                      irq
);
    import pulse_tx_pkg::*;

    logic [31:0] prog_mem [PROG_WORDS];
    irq_t        flags;
    irq_t        flag_set;
    irq_t        flag_clr;
    logic [2:0]  reg_sel;
    logic        reg_write;
    logic        ctrl_write;

    // ----------------------------------------
    // Write decode
    // ----------------------------------------
    // Bit 5 of the address splits registers from program memory
    assign reg_sel    = bus.addr[4:2];
    assign reg_write  = bus.write && !bus.addr[5];
    assign ctrl_write = reg_write && (reg_sel == REG_CTRL);

    // Only enabled events reach the sticky flags
    assign flag_set = events & cfg.irq_mask;
    assign flag_clr = ctrl_write ? bus.wdata[2:0] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg     <= '0;
            flags   <= '0;
            running <= 1'b0;
        end else begin
            // Write 1 clears, a new event in the same cycle still sets
            flags <= (flags & ~flag_clr) | flag_set;

            // Stop first, then start, then end of program
            if (ctrl_write && bus.wdata[STATUS_STOP_BIT]) begin
                running <= 1'b0;
            end else if (ctrl_write && bus.wdata[STATUS_START_BIT]) begin
                running <= 1'b1;
            end else if (finished) begin
                running <= 1'b0;
            end

            if (reg_write) begin
                case (reg_sel)
                    REG_CTRL: begin
                        cfg.irq_mask     <= bus.wdata[10:8];
                        cfg.loop_forever <= bus.wdata[12];
                        cfg.idle_level   <= bus.wdata[13];
                        cfg.invert       <= bus.wdata[14];
                        cfg.carrier_en   <= bus.wdata[15];
                        cfg.two_bit_mode <= bus.wdata[17];
                        cfg.low_sym0     <= bus.wdata[19:18];
                        cfg.low_sym1     <= bus.wdata[21:20];
                        cfg.high_sym0    <= bus.wdata[23:22];
                        cfg.high_sym1    <= bus.wdata[25:24];
                    end
                    REG_PROG: begin
                        cfg.start_idx    <= bus.wdata[7:0];
                        cfg.end_idx      <= bus.wdata[15:8];
                        cfg.loopback_idx <= bus.wdata[23:16];
                        cfg.loop_count   <= bus.wdata[31:24];
                    end
                    REG_DUR: begin
                        cfg.dur_low_a  <= bus.wdata[7:0];
                        cfg.dur_low_b  <= bus.wdata[15:8];
                        cfg.dur_high_a <= bus.wdata[23:16];
                        cfg.dur_high_b <= bus.wdata[31:24];
                    end
                    // Prescaler stays in the top nibble
                    REG_PRESCALE: cfg.prescale <= bus.wdata[31:28];
                    REG_CARRIER:  cfg.carrier_half <= bus.wdata[10:0];
                    default: begin
                    end
                endcase
            end
        end
    end

    // ----------------------------------------
    // Program memory
    // ----------------------------------------
    // Word address in bits [4:2], writes are 32 bits wide
    always_ff @(posedge clk) begin
        if (bus.write && bus.addr[5]) begin
            prog_mem[bus.addr[PROG_ADDR_BITS+1:2]] <= bus.wdata;
        end
    end

    assign prog_word = prog_mem[word_index];

    // Read data ignores the address
    assign read_data = {8'd0, status.loop_cnt, status.pc, 3'd0, running, 1'b0, flags};
    assign irq       = |flags;

endmodule

//--- hdl/pulse_tx_pkg.sv
// Widths, register map, vector typedefs and packed structs for the pulse transmitter
package pulse_tx_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int PROG_WORDS        = 8;
    localparam int PROG_ADDR_BITS    = 3;
    // Prescaler counter covers 2^15 cycles per duration tick
    localparam int PRESCALE_CNT_BITS = 15;

    // Register indices, taken from address bits [4:2]
    localparam logic [2:0] REG_CTRL     = 3'd0;
    localparam logic [2:0] REG_PROG     = 3'd1;
    localparam logic [2:0] REG_DUR      = 3'd2;
    localparam logic [2:0] REG_PRESCALE = 3'd3;
    localparam logic [2:0] REG_CARRIER  = 3'd4;

    // Control register command bits
    localparam int STATUS_START_BIT = 4;
    localparam int STATUS_STOP_BIT  = 5;

    // Interrupt flag positions
    localparam int IRQ_SYMBOL = 0;
    localparam int IRQ_LOOP   = 1;
    localparam int IRQ_END    = 2;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [7:0]  pc_t;
    typedef logic [7:0]  loop_cnt_t;
    typedef logic [7:0]  duration_t;
    typedef logic [3:0]  prescale_t;
    typedef logic [10:0] carrier_t;
    // High bit is the line level, low bit picks the duration
    typedef logic [1:0]  symbol_t;
    typedef logic [2:0]  irq_t;

    typedef struct packed {
        logic [5:0]  addr;
        logic [31:0] wdata;
        logic        write;
    } bus_req_t;

    typedef struct packed {
        irq_t      irq_mask;
        logic      loop_forever;
        logic      idle_level;
        logic      invert;
        logic      carrier_en;
        logic      two_bit_mode;
        // Expansion codes for one-bit mode
        symbol_t   low_sym0;
        symbol_t   low_sym1;
        symbol_t   high_sym0;
        symbol_t   high_sym1;
        pc_t       start_idx;
        pc_t       end_idx;
        pc_t       loopback_idx;
        loop_cnt_t loop_count;
        duration_t dur_low_a;
        duration_t dur_low_b;
        duration_t dur_high_a;
        duration_t dur_high_b;
        prescale_t prescale;
        carrier_t  carrier_half;
    } pulse_cfg_t;

    typedef struct packed {
        pc_t       pc;
        loop_cnt_t loop_cnt;
    } seq_status_t;

endpackage
